// File: tb.f
source/legalizer_pkg.sv
source/burst_fifo.sv
source/page_splitter.sv
source/burst_formatter.sv
source/idma_legalizer_top.sv
bench/clk_gen.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the legalizer testbench with Verilator and runs it once
# the run passes only if the testbench printed its pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_top -Mdir obj_dir

out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -qx "TEST OK"

// File: bench/tb_top.sv
/*
 * burst legalizer testbench
 * directed and LFSR-driven transfers, a burst reference model and
 * concurrent assertions on every delivered burst
 */

`timescale 1ns/100ps
`default_nettype none

module tb_top;

    // request count of each test sets the watchdog limit
    localparam int n_directed = 5;
    localparam int n_random   = 12;
    localparam int n_b2b      = 8;
    localparam int n_requests = n_directed + n_random + n_b2b;
    localparam int page       = legalizer_pkg::page_size;
    localparam int strb       = legalizer_pkg::strb_width;
    localparam int addr_span  = 1 << legalizer_pkg::addr_width;

    // all burst outputs in one vector
    typedef struct packed {
        legalizer_pkg::addr_t     ar_addr;
        legalizer_pkg::beat_len_t ar_len;
        legalizer_pkg::offset_t   r_offset;
        legalizer_pkg::offset_t   r_tailer;
        legalizer_pkg::offset_t   r_shift;
        legalizer_pkg::addr_t     aw_addr;
        legalizer_pkg::beat_len_t aw_len;
        legalizer_pkg::offset_t   w_offset;
        legalizer_pkg::offset_t   w_tailer;
        logic                     w_last;
    } meta_t;

    logic clk;
    logic reset;

    // DUT side
    legalizer_pkg::length_t   req_length;
    legalizer_pkg::addr_t     req_src_addr;
    legalizer_pkg::addr_t     req_dst_addr;
    logic                     req_valid;
    logic                     req_ready;
    logic                     burst_valid;
    logic                     burst_ready;
    legalizer_pkg::addr_t     ar_addr;
    legalizer_pkg::beat_len_t ar_len;
    legalizer_pkg::offset_t   r_offset;
    legalizer_pkg::offset_t   r_tailer;
    legalizer_pkg::offset_t   r_shift;
    legalizer_pkg::addr_t     aw_addr;
    legalizer_pkg::beat_len_t aw_len;
    legalizer_pkg::offset_t   w_offset;
    legalizer_pkg::offset_t   w_tailer;
    logic                     w_last;
    meta_t                    act_meta;

    // reference model with one entry per expected burst
    meta_t       exp_q[$];
    int          exp_id_q[$];
    string       name_of_req[$];
    int          len_of_req[$];
    meta_t       exp_meta;
    string       exp_name;
    logic        exp_present;
    string       cur_test;

    // handshake and stall tracking updated 1 ns after the edge
    logic        fire;
    logic        stall;
    logic        held;
    meta_t       stall_meta;
    meta_t       held_meta;
    logic        seen_req;
    logic        just_taken;
    logic        random_ready;
    int          last_id;
    int          pending_cur;
    int          delivered;
    int          byte_sum;
    int          value_errs;
    int          other_errs;
    logic [31:0] lfsr;

    clk_gen clk_gen0 (
        .clk_o   (clk),
        .reset_o (reset)
    );

    idma_legalizer_top dut0 (
        .clk_i          (clk),
        .reset_i        (reset),
        .req_length_i   (req_length),
        .req_src_addr_i (req_src_addr),
        .req_dst_addr_i (req_dst_addr),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .burst_valid_o  (burst_valid),
        .burst_ready_i  (burst_ready),
        .ar_addr_o      (ar_addr),
        .ar_len_o       (ar_len),
        .r_offset_o     (r_offset),
        .r_tailer_o     (r_tailer),
        .r_shift_o      (r_shift),
        .aw_addr_o      (aw_addr),
        .aw_len_o       (aw_len),
        .w_offset_o     (w_offset),
        .w_tailer_o     (w_tailer),
        .w_last_o       (w_last)
    );

    assign act_meta = {ar_addr, ar_len, r_offset, r_tailer, r_shift,
                       aw_addr, aw_len, w_offset, w_tailer, w_last};

    // --------------------
    // random numbers
    // --------------------
    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit with the msb first
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic predict_bursts(input int id, input int len, input int src,
                                  input int dst, output int count);
        int    rem;
        int    s;
        int    d;
        int    n;
        int    so;
        int    dof;
        meta_t e;
        rem   = len;
        s     = src;
        d     = dst;
        count = 0;
        while (rem > 0) begin
            // nearest of remaining length and both page ends
            n = rem;
            if (page - s % page < n) begin
                n = page - s % page;
            end
            if (page - d % page < n) begin
                n = page - d % page;
            end
            so  = s % strb;
            dof = d % strb;
            e.ar_addr  = legalizer_pkg::addr_t'(s - so);
            e.ar_len   = legalizer_pkg::beat_len_t'((n + so - 1) / strb);
            e.r_offset = legalizer_pkg::offset_t'(so);
            e.r_tailer = legalizer_pkg::offset_t'((n + so) % strb);
            e.r_shift  = legalizer_pkg::offset_t'((so - dof + strb) % strb);
            e.aw_addr  = legalizer_pkg::addr_t'(d - dof);
            e.aw_len   = legalizer_pkg::beat_len_t'((n + dof - 1) / strb);
            e.w_offset = legalizer_pkg::offset_t'(dof);
            e.w_tailer = legalizer_pkg::offset_t'((n + dof) % strb);
            e.w_last   = (n == rem);
            exp_q.push_back(e);
            exp_id_q.push_back(id);
            s      = (s + n) % addr_span;
            d      = (d + n) % addr_span;
            rem   -= n;
            count += 1;
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    // one clock step retires the burst taken at this edge and drives ready
    task automatic next_cycle();
        logic [31:0] bits;
        meta_t       popped;
        int          popped_id;
        int          bytes;
        @(posedge clk);
        #1;
        just_taken = 1'b0;
        held       = stall;
        held_meta  = stall_meta;
        if (fire && exp_q.size() != 0) begin
            popped    = exp_q.pop_front();
            popped_id = exp_id_q.pop_front();
            if (popped_id == last_id) begin
                pending_cur--;
            end
            delivered++;
            // byte count of the delivered burst from its read-side beats
            bytes = (int'(held_meta.ar_len) + 1) * strb - int'(held_meta.r_offset)
                  - (strb - int'(held_meta.r_tailer)) % strb;
            byte_sum += bytes;
            if (popped.w_last) begin
                assert (byte_sum == len_of_req[popped_id]) else begin
                    value_errs++;
                    $display("ERR %s byte sum: expected %0d actual %0d",
                             name_of_req[popped_id], len_of_req[popped_id], byte_sum);
                end
                byte_sum = 0;
            end
        end
        if (random_ready) begin
            take_bits(1, bits);
            burst_ready = bits[0];
        end else begin
            burst_ready = 1'b1;
        end
        // outputs and ready are now stable up to the next edge
        fire        = burst_valid && burst_ready;
        stall       = burst_valid && !burst_ready;
        stall_meta  = act_meta;
        exp_present = (exp_q.size() != 0);
        if (exp_present) begin
            exp_meta = exp_q[0];
            exp_name = name_of_req[exp_id_q[0]];
        end
    endtask

    task automatic send_request(input int len, input int src, input int dst);
        logic taken;
        int   id;
        int   count;
        id = name_of_req.size();
        name_of_req.push_back(cur_test);
        len_of_req.push_back(len);
        req_length   = legalizer_pkg::length_t'(len);
        req_src_addr = legalizer_pkg::addr_t'(src);
        req_dst_addr = legalizer_pkg::addr_t'(dst);
        req_valid    = 1'b1;
        taken        = 1'b0;
        count        = 0;
        while (!taken) begin
            // ready only moves on an edge, so the coming edge takes it
            taken = req_ready;
            if (taken) begin
                predict_bursts(id, len, src, dst, count);
            end
            next_cycle();
        end
        req_valid   = 1'b0;
        seen_req    = 1'b1;
        just_taken  = 1'b1;
        last_id     = id;
        pending_cur = count;
    endtask

    task automatic random_request();
        logic [31:0] len_bits;
        logic [31:0] src_bits;
        logic [31:0] dst_bits;
        take_bits(12, len_bits);
        take_bits(24, src_bits);
        take_bits(24, dst_bits);
        send_request(int'(len_bits) % 3000 + 1, int'(src_bits), int'(dst_bits));
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || burst_valid) begin
            next_cycle();
        end
    endtask

    // --------------------
    // checks
    // --------------------
    a_idle_after_reset: assert property (@(negedge clk) disable iff (reset)
        !seen_req |-> (req_ready && !burst_valid)) else begin
        other_errs++;
        $display("req_ready not high or burst_valid not low before the first request");
    end

    a_burst_expected: assert property (@(negedge clk) disable iff (reset)
        burst_valid |-> exp_present) else begin
        other_errs++;
        $display("%s: a burst is offered but the model expects none", cur_test);
    end

    a_burst_match: assert property (@(negedge clk) disable iff (reset)
        (burst_valid && exp_present) |-> (act_meta == exp_meta)) else begin
        value_errs++;
        $display("ERR %s: expected %h actual %h", exp_name, exp_meta, act_meta);
    end

    // a stalled burst keeps valid and every field
    a_stall_hold: assert property (@(negedge clk) disable iff (reset)
        held |-> (burst_valid && act_meta == held_meta)) else begin
        value_errs++;
        $display("ERR %s hold: expected %h actual %h", exp_name,
                 {1'b1, held_meta}, {burst_valid, act_meta});
    end

    // more bursts left than FIFO plus output register means splitter busy
    a_ready_busy: assert property (@(negedge clk) disable iff (reset)
        (just_taken || pending_cur > legalizer_pkg::fifo_depth + 1) |-> !req_ready)
        else begin
        other_errs++;
        $display("%s: req_ready high while a transfer is still held", cur_test);
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        lfsr         = 32'hc1ceb356;
        req_length   = '0;
        req_src_addr = '0;
        req_dst_addr = '0;
        req_valid    = 1'b0;
        burst_ready  = 1'b0;
        random_ready = 1'b0;
        fire         = 1'b0;
        stall        = 1'b0;
        held         = 1'b0;
        stall_meta   = '0;
        held_meta    = '0;
        exp_meta     = '0;
        exp_present  = 1'b0;
        seen_req     = 1'b0;
        just_taken   = 1'b0;
        last_id      = -1;
        pending_cur  = 0;
        delivered    = 0;
        byte_sum     = 0;
        value_errs   = 0;
        other_errs   = 0;
        exp_name     = "none";
        cur_test     = "reset_idle";
        while (reset !== 1'b0) begin
            @(posedge clk);
        end
        #1;
        repeat (4) next_cycle();

        cur_test = "single_page";
        send_request(40, 24'h001104, 24'h002231);
        send_request(1, 24'h0301ff, 24'h0401fe);
        send_request(512, 24'h000a00, 24'h100400);
        drain();

        cur_test = "cross_pages";
        send_request(1000, 24'h0001f0, 24'h000351);
        drain();

        cur_test = "long_multi";
        send_request(3000, 24'h123457, 24'h0abcde);
        drain();

        cur_test     = "random_ready";
        random_ready = 1'b1;
        for (int i = 0; i < n_random; i++) begin
            random_request();
            drain();
        end

        // next request goes in as soon as the splitter frees up
        cur_test = "back_to_back";
        for (int i = 0; i < n_b2b; i++) begin
            random_request();
        end
        drain();
        repeat (5) next_cycle();

        $display("errors: %0d value, %0d other, %0d bursts checked",
                 value_errs, other_errs, delivered);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (200 * n_requests + 1000) @(posedge clk);
        $display("timeout in %s with %0d bursts still expected", cur_test, exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
/*
 * testbench clock and reset
 * 10 ns clock, reset high for the first two rising edges
 */

`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    // release 1 ns after the last reset edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: source/idma_legalizer_top.sv
/*
 * burst legalizer top level
 * splitter, burst FIFO and formatter in a row, plain ports outside
 */

`timescale 1ns/100ps
`default_nettype none

module idma_legalizer_top (
    input  wire                       clk_i,
    input  wire                       reset_i,

    // 1D transfer request
    input  legalizer_pkg::length_t    req_length_i,
    input  legalizer_pkg::addr_t      req_src_addr_i,
    input  legalizer_pkg::addr_t      req_dst_addr_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,

    // legalized bursts
    output logic                      burst_valid_o,
    input  logic                      burst_ready_i,
    output legalizer_pkg::addr_t      ar_addr_o,
    output legalizer_pkg::beat_len_t  ar_len_o,
    output legalizer_pkg::offset_t    r_offset_o,
    output legalizer_pkg::offset_t    r_tailer_o,
    output legalizer_pkg::offset_t    r_shift_o,
    output legalizer_pkg::addr_t      aw_addr_o,
    output legalizer_pkg::beat_len_t  aw_len_o,
    output legalizer_pkg::offset_t    w_offset_o,
    output legalizer_pkg::offset_t    w_tailer_o,
    output logic                      w_last_o
);

    // --------------------
    // splitter to FIFO
    // --------------------
    logic                  push_valid;
    logic                  push_ready;
    legalizer_pkg::burst_t push_burst;

    // FIFO to formatter
    logic                  pop_valid;
    logic                  pop_ready;
    legalizer_pkg::burst_t pop_burst;

    page_splitter splitter0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_length_i   (req_length_i),
        .req_src_addr_i (req_src_addr_i),
        .req_dst_addr_i (req_dst_addr_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .push_valid_o   (push_valid),
        .push_ready_i   (push_ready),
        .push_burst_o   (push_burst)
    );

    // decouples splitting from downstream stalls
    burst_fifo #(
        .payload_t (legalizer_pkg::burst_t),
        .depth     (legalizer_pkg::fifo_depth)
    ) fifo0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .push_valid_i (push_valid),
        .push_ready_o (push_ready),
        .push_data_i  (push_burst),
        .pop_valid_o  (pop_valid),
        .pop_ready_i  (pop_ready),
        .pop_data_o   (pop_burst)
    );

    burst_formatter formatter0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pop_valid_i   (pop_valid),
        .pop_ready_o   (pop_ready),
        .pop_burst_i   (pop_burst),
        .burst_valid_o (burst_valid_o),
        .burst_ready_i (burst_ready_i),
        .ar_addr_o     (ar_addr_o),
        .ar_len_o      (ar_len_o),
        .r_offset_o    (r_offset_o),
        .r_tailer_o    (r_tailer_o),
        .r_shift_o     (r_shift_o),
        .aw_addr_o     (aw_addr_o),
        .aw_len_o      (aw_len_o),
        .w_offset_o    (w_offset_o),
        .w_tailer_o    (w_tailer_o),
        .w_last_o      (w_last_o)
    );

endmodule

`default_nettype wire

// File: source/burst_formatter.sv
/*
 * burst formatter
 * derives AXI meta values and data-path set-up of one burst and
 * holds them in a single output register stage
 */

`timescale 1ns/100ps
`default_nettype none

module burst_formatter (
    input  wire                       clk_i,
    input  wire                       reset_i,

    // buffered burst
    input  logic                      pop_valid_i,
    output logic                      pop_ready_o,
    input  legalizer_pkg::burst_t     pop_burst_i,

    // legalized burst
    output logic                      burst_valid_o,
    input  logic                      burst_ready_i,
    output legalizer_pkg::addr_t      ar_addr_o,
    output legalizer_pkg::beat_len_t  ar_len_o,
    output legalizer_pkg::offset_t    r_offset_o,
    output legalizer_pkg::offset_t    r_tailer_o,
    output legalizer_pkg::offset_t    r_shift_o,
    output legalizer_pkg::addr_t      aw_addr_o,
    output legalizer_pkg::beat_len_t  aw_len_o,
    output legalizer_pkg::offset_t    w_offset_o,
    output legalizer_pkg::offset_t    w_tailer_o,
    output logic                      w_last_o
);

    // in-beat offsets of both sides
    legalizer_pkg::offset_t   src_off;
    legalizer_pkg::offset_t   dst_off;
    // byte count plus offset, i.e. end of burst relative to the first beat
    legalizer_pkg::page_len_t r_end;
    legalizer_pkg::page_len_t w_end;
    legalizer_pkg::page_len_t r_last_byte;
    legalizer_pkg::page_len_t w_last_byte;
    logic                     load;

    // --------------------
    // meta calculation
    // --------------------
    assign src_off = pop_burst_i.src_addr[legalizer_pkg::offset_width-1:0];
    assign dst_off = pop_burst_i.dst_addr[legalizer_pkg::offset_width-1:0];

    assign r_end = pop_burst_i.num_bytes + legalizer_pkg::page_len_t'(src_off);
    assign w_end = pop_burst_i.num_bytes + legalizer_pkg::page_len_t'(dst_off);

    // index of the final byte, counted from the aligned start
    assign r_last_byte = r_end - legalizer_pkg::page_len_t'(1);
    assign w_last_byte = w_end - legalizer_pkg::page_len_t'(1);

    // --------------------
    // output register
    // --------------------
    // load when empty or drained this cycle
    assign pop_ready_o = !burst_valid_o | burst_ready_i;
    assign load        = pop_valid_i & pop_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            burst_valid_o <= 1'b0;
        end else if (load) begin
            burst_valid_o <= 1'b1;
        end else if (burst_ready_i) begin
            burst_valid_o <= 1'b0;
        end
    end

    // payload only moves on load, so it holds under back-pressure
    always_ff @(posedge clk_i) begin
        if (load) begin
            // read side, bus-aligned address and beats minus one
            ar_addr_o  <= {pop_burst_i.src_addr[legalizer_pkg::addr_width-1:
                                                legalizer_pkg::offset_width],
                           {legalizer_pkg::offset_width{1'b0}}};
            ar_len_o   <= legalizer_pkg::beat_len_t'(r_last_byte >>
                                                     legalizer_pkg::offset_width);
            r_offset_o <= src_off;
            // low bits of the end give the tail position
            r_tailer_o <= legalizer_pkg::offset_t'(r_end);
            // realignment between the two sides
            r_shift_o  <= src_off - dst_off;
            // write side, same rules on the destination
            aw_addr_o  <= {pop_burst_i.dst_addr[legalizer_pkg::addr_width-1:
                                                legalizer_pkg::offset_width],
                           {legalizer_pkg::offset_width{1'b0}}};
            aw_len_o   <= legalizer_pkg::beat_len_t'(w_last_byte >>
                                                     legalizer_pkg::offset_width);
            w_offset_o <= dst_off;
            w_tailer_o <= legalizer_pkg::offset_t'(w_end);
            w_last_o   <= pop_burst_i.last;
        end
    end

endmodule

`default_nettype wire

// File: source/page_splitter.sv
/*
 * page splitter
 * holds one 1D transfer and cuts it into bursts that end at the
 * nearer of the read and write page boundaries
 */

`timescale 1ns/100ps
`default_nettype none

module page_splitter (
    input  wire                     clk_i,
    input  wire                     reset_i,

    // 1D transfer request
    input  legalizer_pkg::length_t  req_length_i,
    input  legalizer_pkg::addr_t    req_src_addr_i,
    input  legalizer_pkg::addr_t    req_dst_addr_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,

    // bursts towards the FIFO
    output logic                    push_valid_o,
    input  logic                    push_ready_i,
    output legalizer_pkg::burst_t   push_burst_o
);

    // transfer in progress
    logic                     busy_q;
    legalizer_pkg::addr_t     src_q;
    legalizer_pkg::addr_t     dst_q;
    legalizer_pkg::length_t   len_q;

    // page boundary distances
    legalizer_pkg::page_len_t src_to_pb;
    legalizer_pkg::page_len_t dst_to_pb;
    legalizer_pkg::page_len_t near_pb;
    legalizer_pkg::page_len_t num_bytes;
    logic                     last;

    // handshakes
    logic                     take;
    logic                     push;

    // --------------------
    // page boundary check
    // --------------------
    // bytes left until the source page ends
    assign src_to_pb = legalizer_pkg::page_len_t'(legalizer_pkg::page_size)
                     - {1'b0, src_q[legalizer_pkg::page_addr_width-1:0]};

    // bytes left until the destination page ends
    assign dst_to_pb = legalizer_pkg::page_len_t'(legalizer_pkg::page_size)
                     - {1'b0, dst_q[legalizer_pkg::page_addr_width-1:0]};

    // coupled mode: the closer boundary wins on both sides
    assign near_pb = (src_to_pb > dst_to_pb) ? dst_to_pb : src_to_pb;

    // cap by what is still left of the transfer
    assign num_bytes = (len_q > legalizer_pkg::length_t'(near_pb)) ?
                       near_pb : legalizer_pkg::page_len_t'(len_q);

    // this burst drains the transfer
    assign last = (legalizer_pkg::length_t'(num_bytes) == len_q);

    // --------------------
    // flow control
    // --------------------
    // new transfer only once the old one is fully pushed
    assign req_ready_o  = !busy_q;
    assign take         = req_valid_i & req_ready_o;

    // one burst per cycle while a transfer is held
    assign push_valid_o = busy_q;
    assign push         = push_valid_o & push_ready_i;

    assign push_burst_o = '{
        src_addr:  src_q,
        dst_addr:  dst_q,
        num_bytes: num_bytes,
        last:      last
    };

    // --------------------
    // state
    // --------------------
    // busy bit, cleared on the edge that pushes the last burst
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (take) begin
            busy_q <= 1'b1;
        end else if (push && last) begin
            busy_q <= 1'b0;
        end
    end

    // addresses and remaining length
    always_ff @(posedge clk_i) begin
        if (take) begin
            src_q <= req_src_addr_i;
            dst_q <= req_dst_addr_i;
            len_q <= req_length_i;
        end else if (push) begin
            // advance both sides by the burst just sent
            src_q <= src_q + legalizer_pkg::addr_t'(num_bytes);
            dst_q <= dst_q + legalizer_pkg::addr_t'(num_bytes);
            len_q <= len_q - legalizer_pkg::length_t'(num_bytes);
        end
    end

endmodule

`default_nettype wire

// File: source/burst_fifo.sv
/*
 * burst FIFO
 * small synchronous circular buffer, payload type set by parameter
 */

`timescale 1ns/100ps
`default_nettype none

module burst_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned depth     = 4
) (
    input  wire      clk_i,
    input  wire      reset_i,

    // write side
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,

    // read side
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output payload_t pop_data_o
);

    // pointer needs at least one bit even for a single entry
    typedef logic [(depth > 1 ? $clog2(depth) : 1)-1:0] ptr_t;
    typedef logic [$clog2(depth+1)-1:0]                 cnt_t;

    payload_t mem_q [depth];
    ptr_t     wr_ptr_q;
    ptr_t     rd_ptr_q;
    cnt_t     count_q;
    logic     push;
    logic     pop;

    // full blocks the writer, empty hides the head
    assign push_ready_o = (count_q != cnt_t'(depth));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // wrap at the last entry
                wr_ptr_q <= (wr_ptr_q == ptr_t'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: source/legalizer_pkg.sv
/*
 * burst legalizer package
 * bus widths, page geometry and the request and burst types shared
 * by the splitter, the burst FIFO and the output formatter
 */

`default_nettype none

package legalizer_pkg;

    // --------------------
    // bus and page geometry
    // --------------------
    // byte address width of both read and write side
    localparam int unsigned addr_width = 24;
    // data bus width in bits
    localparam int unsigned data_width = 16;
    // bytes per beat
    localparam int unsigned strb_width = data_width / 8;
    // bits selecting a byte inside one beat
    localparam int unsigned offset_width = $clog2(strb_width);
    // longest AXI burst in beats
    localparam int unsigned max_beats = 256;
    // a page never exceeds 4 KiB, nor one maximal burst
    localparam int unsigned page_size = (max_beats * strb_width > 4096) ?
                                        4096 : max_beats * strb_width;
    // in-page address bits
    localparam int unsigned page_addr_width = $clog2(page_size);
    // transfer length width in bytes
    localparam int unsigned len_width = 16;
    // bursts buffered between splitter and formatter
    localparam int unsigned fifo_depth = 4;

    // --------------------
    // types
    // --------------------
    typedef logic [addr_width-1:0]        addr_t;
    typedef logic [len_width-1:0]         length_t;
    // one extra bit so a whole page can be counted
    typedef logic [page_addr_width:0]     page_len_t;
    typedef logic [offset_width-1:0]      offset_t;
    // AXI len field, beats minus one
    typedef logic [$clog2(max_beats)-1:0] beat_len_t;

    // one page-legal burst as cut by the splitter
    typedef struct packed {
        addr_t     src_addr;
        addr_t     dst_addr;
        page_len_t num_bytes;
        logic      last;
    } burst_t;

endpackage

`default_nettype wire
